// File: rtl/ip_pkg.sv
package ip_pkg;

  typedef logic [31:0] ipv4_addr_t;
  typedef logic [15:0] port_t;

  // one byte of a stream, framed by sof and eof
  typedef struct packed {
    logic [7:0] data;
    logic       sof;
    logic       eof;
  } stream_t;

  typedef enum logic [7:0] {
    PROTO_ICMP = 8'd1,
    PROTO_UDP  = 8'd17
  } proto_e;

  // remote is the source on receive, the destination on transmit
  typedef struct packed {
    ipv4_addr_t  remote;
    proto_e      proto;
    logic [15:0] length;   // payload bytes
  } ip_meta_t;

  typedef struct packed {
    ipv4_addr_t  remote;
    port_t       port;
    logic [15:0] length;   // user data bytes
  } udp_meta_t;

  localparam logic [7:0] TTL_DEFAULT = 8'd64;

  // ones complement 16-bit add with end-around carry
  function automatic logic [15:0] oc_add(input logic [15:0] a, input logic [15:0] b);
    logic [16:0] s;
    s = a + b;
    return s[15:0] + 16'(s[16]);
  endfunction

endpackage

// File: rtl/ipv4_rx.sv
`timescale 1ns/1ps

module ipv4_rx #(
  parameter int MTU = 256
) (
  input  logic               clk,
  input  logic               reset,
  input  ip_pkg::ipv4_addr_t local_ip,
  input  ip_pkg::stream_t    rx,
  input  logic               rx_valid,
  output ip_pkg::stream_t    pl,
  output ip_pkg::ip_meta_t   pl_meta,
  output logic               pl_valid,
  output logic [15:0]        drop_count
);
  import ip_pkg::*;

  typedef enum logic [1:0] {ST_HDR, ST_PAYLOAD, ST_DISCARD} state_e;

  state_e      state;
  logic [4:0]  hdr_cnt;
  logic [31:0] shift;     // last header bytes, newest in the low byte
  logic [15:0] sum;
  logic [15:0] word;
  logic [7:0]  ver_ihl;
  logic [15:0] tot_len;
  logic        frag;
  proto_e      proto;
  ipv4_addr_t  src;
  logic        first;
  logic        accept;

  assign word = {shift[7:0], rx.data};

  // evaluated on the 20th header byte
  assign accept = ver_ihl == 8'h45 && tot_len >= 16'd20 && tot_len <= 16'(20 + MTU) &&
                  {shift[23:0], rx.data} == local_ip && !frag &&
                  oc_add(sum, word) == 16'hffff;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= ST_HDR;
      hdr_cnt    <= '0;
      first      <= 1'b0;
      pl_valid   <= 1'b0;
      drop_count <= '0;
    end else begin
      pl_valid <= 1'b0;
      if (rx_valid) begin
        case (state)
          ST_HDR: begin
            hdr_cnt <= hdr_cnt + 5'd1;
            if (hdr_cnt == 5'd19) begin
              hdr_cnt <= '0;
              first   <= 1'b1;
              if (!accept) drop_count <= drop_count + 16'd1;
              if (!rx.eof) state <= accept ? ST_PAYLOAD : ST_DISCARD;
            end else if (rx.eof) begin
              hdr_cnt    <= '0;
              drop_count <= drop_count + 16'd1;  // runt
            end
          end
          ST_PAYLOAD: begin
            pl_valid <= 1'b1;
            first    <= 1'b0;
            if (rx.eof) state <= ST_HDR;
          end
          default: if (rx.eof) state <= ST_HDR;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid) begin
      shift <= {shift[23:0], rx.data};
      pl    <= '{rx.data, first, rx.eof};
      if (state == ST_HDR) begin
        if (hdr_cnt[0]) sum <= (hdr_cnt == 5'd1) ? word : oc_add(sum, word);
        case (hdr_cnt)
          5'd0:  ver_ihl <= rx.data;
          5'd3:  tot_len <= word;
          5'd7:  frag <= word[13] || word[12:0] != 13'd0;  // MF or offset
          5'd9:  proto <= proto_e'(rx.data);
          5'd15: src <= {shift[23:0], rx.data};
          5'd19: if (accept) pl_meta <= '{src, proto, tot_len - 16'd20};
          default: ;
        endcase
      end
    end
  end

endmodule

// File: rtl/icmp_echo.sv
`timescale 1ns/1ps

module icmp_echo #(
  parameter int ICMP_MAX_LEN = 64
) (
  input  logic             clk,
  input  logic             reset,
  input  ip_pkg::stream_t  pl,
  input  ip_pkg::ip_meta_t pl_meta,
  input  logic             pl_valid,
  output ip_pkg::stream_t  out,
  output ip_pkg::ip_meta_t out_meta,
  output logic             out_valid,
  input  logic             out_ready
);
  import ip_pkg::*;

  localparam int AW = $clog2(ICMP_MAX_LEN);

  typedef enum logic [1:0] {ST_IDLE, ST_STORE, ST_SEND} state_e;

  state_e      state;
  logic [7:0]  mem [ICMP_MAX_LEN];
  logic [15:0] cnt;      // write index when storing, read index when sending
  logic [7:0]  prev;
  logic [15:0] cksum;
  logic        start;
  logic        wr_en;

  // type 8 request that fits the buffer, whole ICMP message counted
  assign start = pl_valid && pl.sof && pl.data == 8'd8 && pl_meta.proto == PROTO_ICMP &&
                 pl_meta.length >= 16'd8 && pl_meta.length <= 16'(ICMP_MAX_LEN);
  assign wr_en = (state == ST_IDLE && start) || (state == ST_STORE && pl_valid);
  assign out_valid = state == ST_SEND;

  always_comb begin
    out = '{mem[cnt[AW-1:0]], cnt == 16'd0, cnt == out_meta.length - 16'd1};
    case (cnt)
      16'd0: out.data = 8'h00;  // echo reply
      16'd2: out.data = cksum[15:8];
      16'd3: out.data = cksum[7:0];
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        ST_IDLE: if (start) begin
          cnt   <= 16'd1;
          state <= ST_STORE;
        end
        ST_STORE: if (pl_valid) begin
          cnt <= cnt + 16'd1;
          if (pl.eof) begin
            cnt   <= '0;
            state <= ST_SEND;
          end else if (cnt == 16'(ICMP_MAX_LEN - 1)) begin
            cnt   <= '0;
            state <= ST_IDLE;  // longer than announced
          end
        end
        ST_SEND: if (out_ready) begin
          cnt <= cnt + 16'd1;
          if (out.eof) begin
            cnt   <= '0;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[cnt[AW-1:0]] <= pl.data;
      prev <= pl.data;
      if (cnt == 16'd3) cksum <= oc_add({prev, pl.data}, 16'h0800);  // type 8 -> 0
      if (state == ST_IDLE) out_meta <= '{pl_meta.remote, PROTO_ICMP, 16'd0};
      else if (pl.eof) out_meta.length <= cnt + 16'd1;
    end
  end

endmodule

// File: rtl/udp_port.sv
`timescale 1ns/1ps

module udp_port #(
  parameter int MTU = 256
) (
  input  logic              clk,
  input  logic              reset,
  input  ip_pkg::port_t     local_port,
  input  ip_pkg::stream_t   pl,
  input  ip_pkg::ip_meta_t  pl_meta,
  input  logic              pl_valid,
  output ip_pkg::stream_t   udp_rx,
  output ip_pkg::udp_meta_t udp_rx_meta,
  output logic              udp_rx_valid,
  input  ip_pkg::stream_t   udp_tx,
  input  ip_pkg::udp_meta_t udp_tx_meta,
  input  logic              udp_tx_valid,
  output logic              udp_tx_ready,
  output ip_pkg::stream_t   out,
  output ip_pkg::ip_meta_t  out_meta,
  output logic              out_valid,
  input  logic              out_ready
);
  import ip_pkg::*;

  logic [15:0] rx_cnt;
  logic [15:0] rx_idx;
  logic [7:0]  rx_prev;
  logic [15:0] rx_word;
  logic        rx_match;
  logic [3:0]  tx_cnt;    // 0..7 header, 8 data
  logic [15:0] tx_len;
  logic        tx_data;

  assign rx_idx  = pl.sof ? 16'd0 : rx_cnt;
  assign rx_word = {rx_prev, pl.data};

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_cnt       <= '0;
      rx_match     <= 1'b0;
      udp_rx_valid <= 1'b0;
    end else begin
      udp_rx_valid <= pl_valid && rx_match && rx_idx >= 16'd8;
      if (pl_valid) begin
        rx_cnt <= pl.eof ? 16'd0 : rx_idx + 16'd1;
        if (rx_idx == 16'd3) rx_match <= pl_meta.proto == PROTO_UDP && rx_word == local_port;
        if (rx_idx == 16'd5) begin
          rx_match <= rx_match && rx_word == pl_meta.length && rx_word > 16'd8 &&
                      rx_word <= 16'(MTU);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pl_valid) begin
      rx_prev <= pl.data;
      udp_rx  <= '{pl.data, rx_idx == 16'd8, pl.eof};
      if (rx_idx == 16'd0) udp_rx_meta.remote <= pl_meta.remote;
      if (rx_idx == 16'd1) udp_rx_meta.port <= rx_word;        // source port
      if (rx_idx == 16'd5) udp_rx_meta.length <= rx_word - 16'd8;
    end
  end

  assign tx_data      = tx_cnt == 4'd8;
  assign tx_len       = udp_tx_meta.length + 16'd8;
  assign out_meta     = '{udp_tx_meta.remote, PROTO_UDP, tx_len};
  assign out_valid    = udp_tx_valid;
  assign udp_tx_ready = tx_data && out_ready;

  always_comb begin
    out = '{8'h00, tx_cnt == 4'd0, 1'b0};
    case (tx_cnt)
      4'd0: out.data = local_port[15:8];
      4'd1: out.data = local_port[7:0];
      4'd2: out.data = udp_tx_meta.port[15:8];
      4'd3: out.data = udp_tx_meta.port[7:0];
      4'd4: out.data = tx_len[15:8];
      4'd5: out.data = tx_len[7:0];
      4'd8: out = '{udp_tx.data, 1'b0, udp_tx.eof};
      default: ;  // checksum left at zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_cnt <= '0;
    end else if (out_valid && out_ready) begin
      if (!tx_data) tx_cnt <= tx_cnt + 4'd1;
      else if (udp_tx.eof) tx_cnt <= '0;
    end
  end

endmodule

// File: rtl/tx_buf_mng.sv
`timescale 1ns/1ps

module tx_buf_mng #(
  parameter int MTU = 256
) (
  input  logic                   clk,
  input  logic                   reset,
  input  ip_pkg::stream_t  [1:0] src,
  input  ip_pkg::ip_meta_t [1:0] src_meta,
  input  logic             [1:0] src_valid,
  output logic             [1:0] src_ready,
  output ip_pkg::ip_meta_t       hdr_meta,
  output logic                   hdr_valid,
  input  logic                   hdr_ready,
  output ip_pkg::stream_t        pl,
  output logic                   pl_valid,
  input  logic                   pl_ready
);
  import ip_pkg::*;

  localparam int AW    = $clog2(2 * MTU);  // two full packets, power of two
  localparam int DEPTH = 2 ** AW;
  localparam int MQ    = 8;                // packets queued per source
  localparam int MAW   = $clog2(MQ);

  typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_DATA} state_e;
  typedef logic [AW:0]  ptr_t;
  typedef logic [MAW:0] mptr_t;

  state_e   state;
  stream_t  mem [2][DEPTH];
  ip_meta_t meta_q [2][MQ];
  ptr_t     wp [2];
  ptr_t     rp [2];
  mptr_t    mwp [2];
  mptr_t    mrp [2];
  mptr_t    pkt_cnt [2];   // complete packets waiting
  logic     cur;
  logic     rr;
  logic     rd;
  logic [1:0] wr;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      src_ready[s] = ptr_t'(wp[s] - rp[s]) <= ptr_t'(DEPTH - MTU) &&
                     mptr_t'(mwp[s] - mrp[s]) < mptr_t'(MQ);
      wr[s] = src_valid[s] && src_ready[s];
    end
  end

  assign hdr_meta  = meta_q[cur][mrp[cur][MAW-1:0]];
  assign pl        = mem[cur][rp[cur][AW-1:0]];
  assign hdr_valid = state == ST_HDR;
  assign pl_valid  = state == ST_DATA;
  assign rd        = pl_valid && pl_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      cur   <= 1'b0;
      rr    <= 1'b0;  // icmp first
      for (int s = 0; s < 2; s++) begin
        wp[s]      <= '0;
        rp[s]      <= '0;
        mwp[s]     <= '0;
        mrp[s]     <= '0;
        pkt_cnt[s] <= '0;
      end
    end else begin
      for (int s = 0; s < 2; s++) begin
        if (wr[s]) wp[s] <= wp[s] + 1'b1;
        if (wr[s] && src[s].sof) mwp[s] <= mwp[s] + 1'b1;
        pkt_cnt[s] <= pkt_cnt[s] + mptr_t'(wr[s] && src[s].eof) -
                      mptr_t'(rd && pl.eof && cur == 1'(s));
      end
      if (rd) begin
        rp[cur] <= rp[cur] + 1'b1;
        if (pl.eof) mrp[cur] <= mrp[cur] + 1'b1;
      end
      case (state)
        ST_IDLE: begin
          if (pkt_cnt[rr] != '0) begin
            cur   <= rr;
            rr    <= !rr;
            state <= ST_HDR;
          end else if (pkt_cnt[!rr] != '0) begin
            cur   <= !rr;  // rr already points past this one
            state <= ST_HDR;
          end
        end
        ST_HDR: if (hdr_ready) state <= ST_DATA;
        ST_DATA: if (rd && pl.eof) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    for (int s = 0; s < 2; s++) begin
      if (wr[s]) mem[s][wp[s][AW-1:0]] <= src[s];
      if (wr[s] && src[s].sof) meta_q[s][mwp[s][MAW-1:0]] <= src_meta[s];
    end
  end

endmodule

// File: rtl/ipv4_tx.sv
`timescale 1ns/1ps

module ipv4_tx (
  input  logic               clk,
  input  logic               reset,
  input  ip_pkg::ipv4_addr_t local_ip,
  input  ip_pkg::ip_meta_t   hdr_meta,
  input  logic               hdr_valid,
  output logic               hdr_ready,
  input  ip_pkg::stream_t    pl,
  input  logic               pl_valid,
  output logic               pl_ready,
  output ip_pkg::stream_t    tx,
  output logic               tx_valid,
  input  logic               tx_ready
);
  import ip_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_HDR, ST_PAYLOAD} state_e;

  state_e       state;
  logic [15:0]  id;
  logic [159:0] hdr_raw;   // checksum field still zero
  logic [159:0] hdr;       // shifted out msb first
  logic [15:0]  sum;
  logic [4:0]   hdr_cnt;

  always_comb begin
    hdr_raw = {8'h45, 8'h00, hdr_meta.length + 16'd20, id, 16'h4000, TTL_DEFAULT,
               hdr_meta.proto, 16'h0000, local_ip, hdr_meta.remote};
    sum = '0;
    for (int i = 0; i < 10; i++) begin
      sum = oc_add(sum, hdr_raw[159 - 16 * i -: 16]);
    end
  end

  assign hdr_ready = state == ST_IDLE;
  assign pl_ready  = state == ST_PAYLOAD && tx_ready;
  assign tx_valid  = state == ST_HDR || (state == ST_PAYLOAD && pl_valid);
  assign tx = (state == ST_PAYLOAD) ? stream_t'{pl.data, 1'b0, pl.eof} :
                                      stream_t'{hdr[159:152], hdr_cnt == 5'd0, 1'b0};

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ST_IDLE;
      id      <= '0;
      hdr_cnt <= '0;
    end else begin
      case (state)
        ST_IDLE: if (hdr_valid) begin
          id    <= id + 16'd1;
          state <= ST_HDR;
        end
        ST_HDR: if (tx_ready) begin
          hdr_cnt <= hdr_cnt + 5'd1;
          if (hdr_cnt == 5'd19) begin
            hdr_cnt <= '0;
            state   <= ST_PAYLOAD;
          end
        end
        ST_PAYLOAD: if (pl_valid && tx_ready && pl.eof) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && hdr_valid) hdr <= {hdr_raw[159:80], ~sum, hdr_raw[63:0]};
    else if (state == ST_HDR && tx_ready) hdr <= {hdr[151:0], 8'h00};
  end

endmodule

// File: rtl/ip_top.sv
`timescale 1ns/1ps

module ip_top #(
  parameter int MTU          = 256,
  parameter int ICMP_MAX_LEN = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  ip_pkg::ipv4_addr_t local_ip,
  input  ip_pkg::port_t      local_port,
  input  ip_pkg::stream_t    rx,
  input  logic               rx_valid,
  output ip_pkg::stream_t    tx,
  output logic               tx_valid,
  input  logic               tx_ready,
  input  ip_pkg::stream_t    udp_tx,
  input  ip_pkg::udp_meta_t  udp_tx_meta,
  input  logic               udp_tx_valid,
  output logic               udp_tx_ready,
  output ip_pkg::stream_t    udp_rx,
  output ip_pkg::udp_meta_t  udp_rx_meta,
  output logic               udp_rx_valid,
  output logic [15:0]        drop_count
);
  import ip_pkg::*;

  stream_t  pl, icmp_out, udp_out, buf_pl;
  ip_meta_t pl_meta, icmp_meta, udp_meta, hdr_meta;
  logic     pl_valid, icmp_valid, icmp_ready, udp_valid, udp_ready;
  logic     hdr_valid, hdr_ready, buf_pl_valid, buf_pl_ready;

  ipv4_rx #(.MTU(MTU)) ipv4_rx_inst (
    .clk        (clk),
    .reset      (reset),
    .local_ip   (local_ip),
    .rx         (rx),
    .rx_valid   (rx_valid),
    .pl         (pl),
    .pl_meta    (pl_meta),
    .pl_valid   (pl_valid),
    .drop_count (drop_count)
  );

  icmp_echo #(.ICMP_MAX_LEN(ICMP_MAX_LEN)) icmp_echo_inst (
    .clk       (clk),
    .reset     (reset),
    .pl        (pl),
    .pl_meta   (pl_meta),
    .pl_valid  (pl_valid),
    .out       (icmp_out),
    .out_meta  (icmp_meta),
    .out_valid (icmp_valid),
    .out_ready (icmp_ready)
  );

  udp_port #(.MTU(MTU)) udp_port_inst (
    .clk          (clk),
    .reset        (reset),
    .local_port   (local_port),
    .pl           (pl),
    .pl_meta      (pl_meta),
    .pl_valid     (pl_valid),
    .udp_rx       (udp_rx),
    .udp_rx_meta  (udp_rx_meta),
    .udp_rx_valid (udp_rx_valid),
    .udp_tx       (udp_tx),
    .udp_tx_meta  (udp_tx_meta),
    .udp_tx_valid (udp_tx_valid),
    .udp_tx_ready (udp_tx_ready),
    .out          (udp_out),
    .out_meta     (udp_meta),
    .out_valid    (udp_valid),
    .out_ready    (udp_ready)
  );

  // source 0 is icmp, source 1 is udp
  tx_buf_mng #(.MTU(MTU)) tx_buf_mng_inst (
    .clk       (clk),
    .reset     (reset),
    .src       ({udp_out, icmp_out}),
    .src_meta  ({udp_meta, icmp_meta}),
    .src_valid ({udp_valid, icmp_valid}),
    .src_ready ({udp_ready, icmp_ready}),
    .hdr_meta  (hdr_meta),
    .hdr_valid (hdr_valid),
    .hdr_ready (hdr_ready),
    .pl        (buf_pl),
    .pl_valid  (buf_pl_valid),
    .pl_ready  (buf_pl_ready)
  );

  ipv4_tx ipv4_tx_inst (
    .clk       (clk),
    .reset     (reset),
    .local_ip  (local_ip),
    .hdr_meta  (hdr_meta),
    .hdr_valid (hdr_valid),
    .hdr_ready (hdr_ready),
    .pl        (buf_pl),
    .pl_valid  (buf_pl_valid),
    .pl_ready  (buf_pl_ready),
    .tx        (tx),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready)
  );

endmodule

// File: dv/ip_top_tb.sv
`timescale 1ns/1ps

module ip_top_tb;
  import ip_pkg::*;

  localparam int         MTU          = 256;
  localparam int         ICMP_MAX_LEN = 64;
  localparam int         NUM_PKTS     = 15;  // rx packets plus udp_tx datagrams
  localparam int         WATCHDOG     = 200 * NUM_PKTS + 2000;
  localparam ipv4_addr_t LOCAL_IP     = 32'hc0a8_0102;
  localparam port_t      LOCAL_PORT   = 16'd5000;
  localparam ipv4_addr_t PEER_IP      = 32'hc0a8_0164;

  logic        clk = 1'b0;
  logic        reset;
  stream_t     rx, tx, udp_tx, udp_rx;
  logic        rx_valid, tx_valid, tx_ready;
  udp_meta_t   udp_tx_meta, udp_rx_meta;
  logic        udp_tx_valid, udp_tx_ready, udp_rx_valid;
  logic [15:0] drop_count;

  int          errors = 0;
  int          checks = 0;
  int          cycle = 0;

  // tx monitor state, packets stored back to back
  logic [7:0]  tx_bytes[$];
  int          tx_lens[$];
  int          tx_cur = 0;
  logic        in_pkt = 1'b0;
  logic [7:0]  cur_proto;
  int          icmp_seen = 0;
  int          udp_seen = 0;
  int          tx_expected = 0;
  logic [15:0] next_id = '0;

  // udp_rx monitor state
  logic [7:0]  urx_bytes[$];
  int          urx_cyc[$];
  udp_meta_t   urx_meta[$];
  int          urx_lens[$];
  int          urx_cur = 0;
  int          urx_count = 0;
  int          urx_expected = 0;

  // expected traffic
  logic [7:0]  exp_icmp[$];
  int          exp_icmp_len[$];
  ipv4_addr_t  exp_icmp_dst[$];
  logic [7:0]  exp_udp[$];
  int          exp_udp_len[$];
  udp_meta_t   exp_udp_meta[$];
  logic [7:0]  exp_urx_bytes[$];
  int          exp_urx_cyc[$];
  udp_meta_t   exp_urx_meta[$];
  int          exp_urx_len[$];

  logic [7:0]  pkt[$];    // whole ip packet for rx
  logic [7:0]  body[$];   // ip payload
  int          rx_cyc[$];

  ip_top #(.MTU(MTU), .ICMP_MAX_LEN(ICMP_MAX_LEN)) dut0 (
    .clk          (clk),
    .reset        (reset),
    .local_ip     (LOCAL_IP),
    .local_port   (LOCAL_PORT),
    .rx           (rx),
    .rx_valid     (rx_valid),
    .tx           (tx),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .udp_tx       (udp_tx),
    .udp_tx_meta  (udp_tx_meta),
    .udp_tx_valid (udp_tx_valid),
    .udp_tx_ready (udp_tx_ready),
    .udp_rx       (udp_rx),
    .udp_rx_meta  (udp_rx_meta),
    .udp_rx_valid (udp_rx_valid),
    .drop_count   (drop_count)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("CHECK FAILED time=%0t signal=%s expected=%0h actual=%0h", $time, name, exp, act);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("ERROR at time %0t: %s", $time, what);
    end
  endtask

  // internet checksum sum over n bytes, odd tail padded with zero
  function automatic logic [15:0] sum16(input logic [7:0] b[$], input int first, input int n);
    logic [31:0] acc;
    acc = '0;
    for (int i = 0; i < n; i += 2) begin
      acc += {b[first + i], (i + 1 < n) ? b[first + i + 1] : 8'h00};
    end
    while (acc[31:16] != 16'd0) acc = acc[15:0] + acc[31:16];
    return acc[15:0];
  endfunction

  function automatic logic [7:0] pattern(input int seed, input int i);
    return 8'(seed * 37 + i * 11 + 5);
  endfunction

  always @(posedge clk) begin
    if (!reset && tx_valid && tx_ready) begin
      check_true(tx.sof == !in_pkt, "tx sof out of place, packets interleaved or split");
      tx_bytes.push_back(tx.data);
      if (tx_cur == 9) cur_proto = tx.data;
      tx_cur++;
      in_pkt = !tx.eof;
      if (tx.eof) begin
        tx_lens.push_back(tx_cur);
        tx_cur = 0;
        if (cur_proto == 8'd1) icmp_seen++;
        else udp_seen++;
      end
    end
  end

  always @(posedge clk) begin
    if (!reset && udp_rx_valid) begin
      urx_bytes.push_back(udp_rx.data);
      urx_cyc.push_back(cycle);
      if (udp_rx.sof) urx_meta.push_back(udp_rx_meta);
      urx_cur++;
      if (udp_rx.eof) begin
        urx_lens.push_back(urx_cur);
        urx_cur = 0;
        urx_count++;
      end
    end
  end

  task automatic build_ip(input ipv4_addr_t src, input ipv4_addr_t dst, input logic [7:0] proto,
                          input logic [3:0] version, input logic corrupt);
    logic [159:0] hdr;
    logic [15:0]  ck;
    hdr = {version, 4'd5, 8'h00, 16'(20 + body.size()), 16'h1234, 16'h4000, 8'd32, proto,
           16'h0000, src, dst};
    pkt = {};
    for (int i = 0; i < 20; i++) pkt.push_back(hdr[159 - 8 * i -: 8]);
    ck = ~sum16(pkt, 0, 20);
    if (corrupt) ck = ck ^ 16'h0101;
    pkt[10] = ck[15:8];
    pkt[11] = ck[7:0];
    foreach (body[i]) pkt.push_back(body[i]);
  endtask

  task automatic build_icmp(input int n, input int seed);
    logic [15:0] ck;
    body = {};
    for (int i = 0; i < 8 + n; i++) begin
      if (i == 0) body.push_back(8'd8);  // echo request
      else if (i < 4) body.push_back(8'h00);
      else body.push_back(pattern(seed, i));
    end
    ck = ~sum16(body, 0, body.size());
    body[2] = ck[15:8];
    body[3] = ck[7:0];
  endtask

  task automatic build_udp(input port_t sport, input port_t dport, input int n, input int seed);
    logic [63:0] h;
    h = {sport, dport, 16'(n + 8), 16'h0000};
    body = {};
    for (int i = 0; i < 8 + n; i++) begin
      if (i < 8) body.push_back(h[63 - 8 * i -: 8]);
      else body.push_back(pattern(seed, i));
    end
  endtask

  task automatic send_rx();
    rx_cyc = {};
    foreach (pkt[i]) begin
      @(negedge clk);
      rx_valid = 1'b1;
      rx.data  = pkt[i];
      rx.sof   = (i == 0);
      rx.eof   = (i == pkt.size() - 1);
      rx_cyc.push_back(cycle);
    end
    @(negedge clk);
    rx_valid = 1'b0;
    @(negedge clk);  // idle gap between packets
  endtask

  task automatic send_echo(input int n, input int seed, input ipv4_addr_t src);
    build_icmp(n, seed);
    foreach (body[i]) exp_icmp.push_back(body[i]);
    exp_icmp_len.push_back(body.size());
    exp_icmp_dst.push_back(src);
    tx_expected++;
    build_ip(src, LOCAL_IP, 8'd1, 4'd4, 1'b0);
    send_rx();
  endtask

  // each payload byte due 2 cycles after its rx byte
  task automatic expect_udp_rx(input ipv4_addr_t src, input port_t sport, input int n);
    udp_meta_t m;
    m = '{src, sport, 16'(n)};
    exp_urx_meta.push_back(m);
    exp_urx_len.push_back(n);
    for (int i = 0; i < n; i++) begin
      exp_urx_bytes.push_back(body[8 + i]);
      exp_urx_cyc.push_back(rx_cyc[28 + i] + 2);
    end
    urx_expected++;
  endtask

  task automatic send_udp_tx(input ipv4_addr_t dst, input port_t dport, input int n,
                             input int seed);
    udp_meta_t m;
    m = '{dst, dport, 16'(n)};
    exp_udp_meta.push_back(m);
    exp_udp_len.push_back(n);
    tx_expected++;
    @(negedge clk);
    udp_tx_meta = m;
    for (int i = 0; i < n; i++) begin
      udp_tx_valid = 1'b1;
      udp_tx.data  = pattern(seed, i);
      udp_tx.sof   = (i == 0);
      udp_tx.eof   = (i == n - 1);
      exp_udp.push_back(udp_tx.data);
      while (!udp_tx_ready) @(negedge clk);
      @(negedge clk);  // byte taken on the posedge in between
    end
    udp_tx_valid = 1'b0;
  endtask

  task automatic check_icmp_reply(input logic [7:0] p[$]);
    int         n;
    logic [7:0] b;
    if (exp_icmp_len.size() == 0) begin
      check_true(1'b0, "icmp packet on tx that no request asked for");
    end else begin
      n = exp_icmp_len.pop_front();
      check_eq("tx.dst_addr", exp_icmp_dst.pop_front(), {p[16], p[17], p[18], p[19]});
      check_eq("icmp.length", n, p.size() - 20);
      check_eq("icmp.type", 8'd0, p[20]);
      check_eq("icmp.checksum_sum", 16'hffff, sum16(p, 20, p.size() - 20));
      for (int i = 0; i < n; i++) begin
        b = exp_icmp.pop_front();
        if (i != 0 && i != 2 && i != 3) check_eq("icmp.payload", b, p[20 + i]);
      end
    end
  endtask

  task automatic check_udp_out(input logic [7:0] p[$]);
    int        n;
    udp_meta_t m;
    if (exp_udp_len.size() == 0) begin
      check_true(1'b0, "udp packet on tx that was never sent on udp_tx");
    end else begin
      n = exp_udp_len.pop_front();
      m = exp_udp_meta.pop_front();
      check_eq("tx.dst_addr", m.remote, {p[16], p[17], p[18], p[19]});
      check_eq("tx.total_length", n + 28, {p[2], p[3]});
      check_eq("udp.src_port", LOCAL_PORT, {p[20], p[21]});
      check_eq("udp.dst_port", m.port, {p[22], p[23]});
      check_eq("udp.length", n + 8, {p[24], p[25]});
      check_eq("udp.checksum", 16'h0000, {p[26], p[27]});
      check_eq("tx.size", n + 28, p.size());
      for (int i = 0; i < n; i++) check_eq("udp.data", exp_udp.pop_front(), p[28 + i]);
    end
  endtask

  task automatic check_tx_packets();
    logic [7:0] p[$];
    int         n;
    while (tx_lens.size() > 0) begin
      n = tx_lens.pop_front();
      p = {};
      for (int i = 0; i < n; i++) p.push_back(tx_bytes.pop_front());
      if (n < 28) begin
        check_true(1'b0, "tx packet shorter than an ip header plus 8 bytes");
      end else begin
        check_eq("tx.ver_ihl", 8'h45, p[0]);
        check_eq("tx.total_length", n, {p[2], p[3]});
        check_eq("tx.id", next_id, {p[4], p[5]});
        check_eq("tx.flags", 16'h4000, {p[6], p[7]});
        check_eq("tx.ttl", TTL_DEFAULT, p[8]);
        check_eq("tx.checksum_sum", 16'hffff, sum16(p, 0, 20));
        check_eq("tx.src_addr", LOCAL_IP, {p[12], p[13], p[14], p[15]});
        if (p[9] == 8'd1) check_icmp_reply(p);
        else if (p[9] == 8'd17) check_udp_out(p);
        else check_true(1'b0, "tx packet with a protocol that nothing sends");
      end
      next_id++;
    end
  endtask

  task automatic check_udp_rx_packets();
    int n;
    while (urx_lens.size() > 0 && exp_urx_len.size() > 0) begin
      n = urx_lens.pop_front();
      check_eq("udp_rx.length", exp_urx_len.pop_front(), n);
      check_eq("udp_rx_meta", exp_urx_meta.pop_front(), urx_meta.pop_front());
      for (int i = 0; i < n; i++) begin
        check_eq("udp_rx.data", exp_urx_bytes.pop_front(), urx_bytes.pop_front());
        check_eq("udp_rx.cycle", exp_urx_cyc.pop_front(), urx_cyc.pop_front());
      end
    end
  endtask

  task automatic wait_tx();
    while (icmp_seen + udp_seen < tx_expected) @(negedge clk);
  endtask

  initial begin
    void'($urandom(27040));
    tx_ready = 1'b0;
    forever begin
      @(negedge clk);
      tx_ready = ($urandom % 4) != 0;  // ready about 3 cycles in 4
    end
  end

  initial begin
    repeat (WATCHDOG) @(posedge clk);
    $display("timeout after %0d cycles, traffic still missing", WATCHDOG);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    int          icmp_base;
    logic [15:0] drop_base;
    reset        = 1'b1;
    rx_valid     = 1'b0;
    rx           = '0;
    udp_tx       = '0;
    udp_tx_meta  = '0;
    udp_tx_valid = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    check_eq("tx_valid", 1'b0, tx_valid);
    check_eq("udp_rx_valid", 1'b0, udp_rx_valid);
    check_eq("udp_tx_ready", 1'b0, udp_tx_ready);
    check_eq("drop_count", 16'd0, drop_count);

    // echo request and reply
    send_echo(16, 1, PEER_IP);
    wait_tx();
    check_tx_packets();

    // bad checksum, wrong destination, version 6
    drop_base = drop_count;
    build_udp(16'd4321, LOCAL_PORT, 6, 2);
    build_ip(PEER_IP, LOCAL_IP, 8'd17, 4'd4, 1'b1);
    send_rx();
    build_ip(PEER_IP, LOCAL_IP ^ 32'h1, 8'd17, 4'd4, 1'b0);
    send_rx();
    build_ip(PEER_IP, LOCAL_IP, 8'd17, 4'd6, 1'b0);
    send_rx();
    repeat (20) @(negedge clk);
    check_eq("drop_count", drop_base + 16'd3, drop_count);
    check_eq("tx packet count", tx_expected, icmp_seen + udp_seen);
    check_eq("udp_rx packet count", urx_expected, urx_count);

    // udp receive, to local_port and to another port
    build_udp(16'd4321, LOCAL_PORT, 12, 3);
    build_ip(PEER_IP, LOCAL_IP, 8'd17, 4'd4, 1'b0);
    send_rx();
    expect_udp_rx(PEER_IP, 16'd4321, 12);
    build_udp(16'd4321, LOCAL_PORT + 16'd1, 9, 4);
    build_ip(PEER_IP, LOCAL_IP, 8'd17, 4'd4, 1'b0);
    send_rx();
    while (urx_count < urx_expected) @(negedge clk);
    repeat (10) @(negedge clk);
    check_eq("udp_rx packet count", urx_expected, urx_count);
    check_udp_rx_packets();

    // udp transmit
    send_udp_tx(PEER_IP, 16'd7000, 20, 5);
    send_udp_tx(PEER_IP + 32'd2, 16'd7001, 5, 6);
    wait_tx();
    check_tx_packets();

    // echo and udp_tx at the same time
    icmp_base = icmp_seen;
    fork
      begin
        for (int k = 0; k < 3; k++) begin
          send_echo(8 + 12 * k, 10 + k, PEER_IP + 32'(k));
          while (icmp_seen < icmp_base + k + 1) @(negedge clk);  // one request in flight
        end
      end
      begin
        for (int k = 0; k < 4; k++) begin
          send_udp_tx(PEER_IP + 32'(10 + k), 16'(8000 + k), 10 + 7 * k, 20 + k);
        end
      end
    join
    wait_tx();
    check_tx_packets();

    check_eq("drop_count", 16'd3, drop_count);
    check_eq("pending tx packets", 0, exp_icmp_len.size() + exp_udp_len.size());
    check_eq("pending udp_rx packets", 0, exp_urx_len.size());

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
rtl/ip_pkg.sv
rtl/ipv4_rx.sv
rtl/icmp_echo.sv
rtl/udp_port.sv
rtl/tx_buf_mng.sv
rtl/ipv4_tx.sv
rtl/ip_top.sv
dv/ip_top_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ip_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module ip_top_tb -o ip_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/ip_top_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
  exit 0
fi
exit 1
